// File: logic/dsp_pkg.sv
// Sample datapath shared types

package dsp_pkg;

    // Width of the gain shift amount, range 0..15
    localparam int SHIFT_W = 4;

    // Rounding applied when dropping the low sample bits
    typedef enum logic [1:0] {
        ROUND_TRUNC   = 2'd0,  // Toward negative infinity
        ROUND_TO_ZERO = 2'd1,  // Toward zero
        ROUND_NEAREST = 2'd2,  // Half up, clamped at positive max
        ROUND_RSVD    = 2'd3   // Illegal, decoded as truncate
    } round_mode_e;

    // Valid bits of the two fixed pipeline stages ahead of the FIFO
    typedef struct packed {
        logic gain_valid;   // Output of the shift stage
        logic round_valid;  // Output of the rounding stage
    } pipe_status_t;

endpackage

// File: logic/cfg_pkg.sv
// Width reducer configuration

package cfg_pkg;

    // Static settings, held stable while beats are in flight
    typedef struct packed {
        dsp_pkg::round_mode_e         mode;   // Rounding mode
        logic [dsp_pkg::SHIFT_W-1:0]  shift;  // Gain as a left shift
    } shrink_cfg_t;

endpackage

// File: logic/scale_shift.sv
// Saturating gain stage

`timescale 1ns/1ps

module scale_shift #(
    parameter int CH_NUM  = 2,
    parameter int BITS_IN = 16
) (
    input  logic                               clk_i,
    input  logic                               rst_i,

    input  logic [dsp_pkg::SHIFT_W-1:0]        shift_i,

    input  logic [CH_NUM-1:0][BITS_IN-1:0]     tdata_i,
    input  logic                               tvalid_i,

    output logic [CH_NUM-1:0][BITS_IN-1:0]     tdata_o,
    output logic [CH_NUM-1:0]                  sat_o,
    output logic                               tvalid_o
);

    // Largest shift the config can ask for
    localparam int EXT = (1 << dsp_pkg::SHIFT_W) - 1;
    localparam int WW  = BITS_IN + EXT;

    localparam logic [BITS_IN-1:0] S_MAX = {1'b0, {(BITS_IN - 1) {1'b1}}};
    localparam logic [BITS_IN-1:0] S_MIN = {1'b1, {(BITS_IN - 1) {1'b0}}};

    logic [CH_NUM-1:0][BITS_IN-1:0] shifted;
    logic [CH_NUM-1:0]              sat;

    for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
        logic          sign;
        logic [WW-1:0] wide;
        logic [EXT:0]  upper;  // Result sign bit and everything above it
        logic          ovf;

        assign sign  = tdata_i[i][BITS_IN-1];
        assign wide  = {{EXT{sign}}, tdata_i[i]} << shift_i;
        assign upper = wide[WW-1:BITS_IN-1];

        // Any bit above the kept range that differs from the sign means overflow
        assign ovf = sign ? ~(&upper) : (|upper);

        assign shifted[i] = ovf ? (sign ? S_MIN : S_MAX) : wide[BITS_IN-1:0];
        assign sat[i]     = ovf;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
        end
        tdata_o <= shifted;
        sat_o   <= sat;
    end

endmodule

// File: logic/round.sv
// Width reduction with selectable rounding

`timescale 1ns/1ps

module round #(
    parameter int CH_NUM   = 2,
    parameter int BITS_IN  = 16,
    parameter int BITS_OUT = 8
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    input  dsp_pkg::round_mode_e                  mode_i,

    input  logic [CH_NUM-1:0][BITS_IN-1:0]        tdata_i,
    input  logic [CH_NUM-1:0]                     sat_i,
    input  logic                                  tvalid_i,

    output logic [CH_NUM-1:0][BITS_OUT-1:0]       tdata_o,
    output logic [CH_NUM-1:0][BITS_IN-BITS_OUT:0] err_o,
    output logic [CH_NUM-1:0]                     sat_o,
    output logic                                  tvalid_o
);

    localparam int K = BITS_IN - BITS_OUT;  // Dropped bits

    logic [CH_NUM-1:0][BITS_OUT-1:0] out;
    logic [CH_NUM-1:0][K:0]          err;

    for (genvar i = 0; i < CH_NUM; i++) begin : g_ch
        logic               sign;
        logic               corr;
        logic               corr_rtz;
        logic               corr_nearest;
        logic               corr_nearest_safe;
        logic [BITS_IN-1:0] diff;

        assign sign         = tdata_i[i][BITS_IN-1];
        assign corr_rtz     = sign & (|tdata_i[i][K-1:0]);  // Negative with a fraction
        assign corr_nearest = tdata_i[i][K-1];              // Half bit

        if (BITS_OUT > 1) begin : g_safe
            // Kept value already at positive max, rounding up would wrap
            assign corr_nearest_safe =
                (~sign & (&tdata_i[i][BITS_IN-2:K])) ? 1'b0 : corr_nearest;
        end else begin : g_sign_only
            // Only the sign survives, so a positive sample cannot round up
            assign corr_nearest_safe = sign & corr_nearest;
        end

        always_comb begin
            case (mode_i)
                dsp_pkg::ROUND_TO_ZERO: corr = corr_rtz;
                dsp_pkg::ROUND_NEAREST: corr = corr_nearest_safe;
                default:                corr = 1'b0;  // Truncate, reserved code too
            endcase
        end

        assign out[i] = tdata_i[i][BITS_IN-1 -: BITS_OUT] + BITS_OUT'(corr);

        // Residual against the rounded value scaled back up
        assign diff   = tdata_i[i] - {out[i], {K{1'b0}}};
        assign err[i] = diff[K:0];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
        end
        tdata_o <= out;
        err_o   <= err;
        sat_o   <= sat_i;  // Follows its sample
    end

    // Config comes from the top and must never carry the reserved code with data
    a_mode_legal: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tvalid_i |-> (mode_i != dsp_pkg::ROUND_RSVD)
    ) else $error("round: reserved rounding mode with valid data");

endmodule

// File: logic/credit_fifo.sv
// Output FIFO with credit for in-flight beats

`timescale 1ns/1ps

module credit_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_i,

    input  logic [WIDTH-1:0] wr_data_i,
    input  logic             wr_valid_i,
    input  logic [1:0]       inflight_i,  // Valid stages upstream, incl. the write stage
    output logic             wr_ready_o,

    output logic [WIDTH-1:0] rd_data_o,
    output logic             rd_valid_o,
    input  logic             rd_ready_i
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    if (DEPTH < 4) begin : g_depth_check
        $error("credit_fifo: DEPTH must be at least 4");
    end

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic [CW-1:0]   count_next;
    logic            do_wr;
    logic            do_rd;
    logic [1:0]      stage1_beats;
    logic [CW+1:0]   committed;
    logic            ready_next;

    // Room is reserved before the beat enters the pipeline, so writes never wait
    assign do_wr = wr_valid_i;
    assign do_rd = rd_valid_o & rd_ready_i;

    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];

    assign count_next = count + CW'(do_wr) - CW'(do_rd);

    // Beat one stage back, it lands next cycle
    assign stage1_beats = inflight_i - {1'b0, wr_valid_i};

    // Worst case after this edge: stored, stage 1 moving on, one new accept
    assign committed  = (CW + 2)'(count_next) + (CW + 2)'(stage1_beats) + (CW + 2)'(1);
    assign ready_next = (committed < (CW + 2)'(DEPTH));

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            wr_ready_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count_next;
            wr_ready_o <= ready_next;
        end
    end

    // Upstream credit must keep a slot free for every beat it lets in
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_valid_i |-> (count != CW'(DEPTH))
    ) else $error("credit_fifo: write while full");

endmodule

// File: logic/sample_shrink_top.sv
// Sample width reducer top

`timescale 1ns/1ps

module sample_shrink_top #(
    parameter int CH_NUM     = 2,
    parameter int BITS_IN    = 16,
    parameter int BITS_OUT   = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    input  cfg_pkg::shrink_cfg_t                  cfg_i,

    input  logic [CH_NUM-1:0][BITS_IN-1:0]        tdata_i,
    input  logic                                  tvalid_i,
    output logic                                  tready_o,

    output logic [CH_NUM-1:0][BITS_OUT-1:0]       tdata_o,
    output logic [CH_NUM-1:0][BITS_IN-BITS_OUT:0] err_o,
    output logic [CH_NUM-1:0]                     sat_o,
    output logic                                  tvalid_o,
    input  logic                                  tready_i
);

    localparam int ERR_W = BITS_IN - BITS_OUT + 1;

    if (BITS_OUT >= BITS_IN) begin : g_width_check
        $error("sample_shrink_top: BITS_OUT must be less than BITS_IN");
    end

    // One FIFO entry
    typedef struct packed {
        logic [CH_NUM-1:0][BITS_OUT-1:0] data;
        logic [CH_NUM-1:0][ERR_W-1:0]    err;
        logic [CH_NUM-1:0]               sat;
    } beat_t;

    logic                           in_fire;
    logic [CH_NUM-1:0][BITS_IN-1:0] gain_data;
    logic [CH_NUM-1:0]              gain_sat;
    logic [CH_NUM-1:0]              round_sat;
    dsp_pkg::pipe_status_t          pipe;
    logic [1:0]                     inflight;
    beat_t                          wr_word;
    beat_t                          rd_word;

    assign in_fire = tvalid_i & tready_o;

    scale_shift #(
        .CH_NUM (CH_NUM),
        .BITS_IN(BITS_IN)
    ) u_scale (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .shift_i (cfg_i.shift),
        .tdata_i (tdata_i),
        .tvalid_i(in_fire),
        .tdata_o (gain_data),
        .sat_o   (gain_sat),
        .tvalid_o(pipe.gain_valid)
    );

    round #(
        .CH_NUM  (CH_NUM),
        .BITS_IN (BITS_IN),
        .BITS_OUT(BITS_OUT)
    ) u_round (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .mode_i  (cfg_i.mode),
        .tdata_i (gain_data),
        .sat_i   (gain_sat),
        .tvalid_i(pipe.gain_valid),
        .tdata_o (wr_word.data),
        .err_o   (wr_word.err),
        .sat_o   (round_sat),
        .tvalid_o(pipe.round_valid)
    );

    assign wr_word.sat = round_sat;

    // Beats between the input port and the FIFO storage
    assign inflight = 2'(pipe.gain_valid) + 2'(pipe.round_valid);

    credit_fifo #(
        .WIDTH($bits(beat_t)),
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_data_i (wr_word),
        .wr_valid_i(pipe.round_valid),
        .inflight_i(inflight),
        .wr_ready_o(tready_o),
        .rd_data_o (rd_word),
        .rd_valid_o(tvalid_o),
        .rd_ready_i(tready_i)
    );

    assign tdata_o = rd_word.data;
    assign err_o   = rd_word.err;
    assign sat_o   = rd_word.sat;

endmodule

// File: verif/sample_shrink_tb.sv
// Sample width reducer testbench

`timescale 1ns/1ps

module sample_shrink_tb;

    localparam int CH_NUM     = 2;
    localparam int BITS_IN    = 16;
    localparam int BITS_OUT   = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int K          = BITS_IN - BITS_OUT;
    localparam int ERR_W      = K + 1;

    localparam int BEATS_PER_MODE = 300;
    localparam int N_DIRECTED     = 8;
    localparam int SHIFT_GROUPS   = 20;
    localparam int GROUP_BEATS    = 15;
    localparam int STALL_BEATS    = 300;
    localparam int TOTAL_BEATS    = 3 * BEATS_PER_MODE + N_DIRECTED
                                  + SHIFT_GROUPS * GROUP_BEATS + STALL_BEATS + 1;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    localparam longint S_MAX = (longint'(1) << (BITS_IN - 1)) - 1;
    localparam longint S_MIN = -(longint'(1) << (BITS_IN - 1));
    localparam longint O_MAX = (longint'(1) << (BITS_OUT - 1)) - 1;

    // Expected output beat, same layout as the DUT ports
    typedef struct packed {
        logic [CH_NUM-1:0][BITS_OUT-1:0] data;
        logic [CH_NUM-1:0][ERR_W-1:0]    err;
        logic [CH_NUM-1:0]               sat;
    } exp_beat_t;

    logic                            clk_i;
    logic                            rst_i;
    cfg_pkg::shrink_cfg_t            cfg_i;
    logic [CH_NUM-1:0][BITS_IN-1:0]  tdata_i;
    logic                            tvalid_i;
    logic                            tready_o;
    logic [CH_NUM-1:0][BITS_OUT-1:0] tdata_o;
    logic [CH_NUM-1:0][ERR_W-1:0]    err_o;
    logic [CH_NUM-1:0]               sat_o;
    logic                            tvalid_o;
    logic                            tready_i;

    exp_beat_t exp_q[$];       // Accepted beats not yet seen at the output
    int        cycle_cnt = 0;
    int        ready_pct = 0;  // Sink ready probability in percent
    bit        saw_stall = 1'b0;
    bit        prev_stall = 1'b0;
    exp_beat_t prev_word;

    logic [BITS_IN-1:0] edge_vals [N_DIRECTED] = '{
        16'h7FFF, 16'h8000, 16'h0080, 16'hFF80,
        16'h00FF, 16'hFFFF, 16'h7F80, 16'h8080
    };

    sample_shrink_top #(
        .CH_NUM    (CH_NUM),
        .BITS_IN   (BITS_IN),
        .BITS_OUT  (BITS_OUT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) UUT (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cfg_i   (cfg_i),
        .tdata_i (tdata_i),
        .tvalid_i(tvalid_i),
        .tready_o(tready_o),
        .tdata_o (tdata_o),
        .err_o   (err_o),
        .sat_o   (sat_o),
        .tvalid_o(tvalid_o),
        .tready_i(tready_i)
    );

    always #10 clk_i = ~clk_i;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            stop_with_failure("Value check failed");
        end
    endtask

    // Gain, rounding and error computed in plain integer arithmetic
    function automatic exp_beat_t model_beat(input logic [CH_NUM-1:0][BITS_IN-1:0] din,
                                             input cfg_pkg::shrink_cfg_t cfg);
        exp_beat_t e;
        longint    s;
        longint    kept;
        longint    frac;
        longint    outv;
        longint    errv;
        logic      sat;
        logic      corr;
        e = '0;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            s   = longint'($signed(din[ch]));
            s   = s * (longint'(1) << cfg.shift);
            sat = 1'b0;
            if (s > S_MAX) begin
                s   = S_MAX;
                sat = 1'b1;
            end else if (s < S_MIN) begin
                s   = S_MIN;
                sat = 1'b1;
            end
            kept = s >>> K;            // Floor division
            frac = s - (kept <<< K);   // Always 0 .. 2^K-1
            case (cfg.mode)
                dsp_pkg::ROUND_TO_ZERO: corr = (s < 0) && (frac != 0);
                dsp_pkg::ROUND_NEAREST:
                    corr = (frac >= (longint'(1) << (K - 1))) && (kept != O_MAX);
                default:                corr = 1'b0;
            endcase
            outv = kept + longint'(corr);
            errv = s - (outv <<< K);
            e.data[ch] = BITS_OUT'(outv);
            e.err[ch]  = ERR_W'(errv);
            e.sat[ch]  = sat;
        end
        return e;
    endfunction

    function automatic logic [CH_NUM-1:0][BITS_IN-1:0] random_data();
        logic [CH_NUM-1:0][BITS_IN-1:0] d;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            d[ch] = BITS_IN'($urandom);
        end
        return d;
    endfunction

    // Starts and ends 2 ns after a rising edge, returns right after acceptance
    task automatic send_beat(input logic [CH_NUM-1:0][BITS_IN-1:0] din, input int gap);
        for (int g = 0; g < gap; g++) begin
            @(posedge clk_i);
            #2;
        end
        tdata_i  = din;
        tvalid_i = 1'b1;
        @(posedge clk_i);
        while (!tready_o) @(posedge clk_i);
        #2;
        tvalid_i = 1'b0;
        tdata_i  = '0;
    endtask

    task automatic send_random(input int n, input int max_gap);
        for (int b = 0; b < n; b++) begin
            send_beat(random_data(), $urandom % (max_gap + 1));
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout, the run did not finish within its cycle limit");
        end
    end

    always @(posedge clk_i) begin
        #2;
        tready_i = ($urandom % 100) < ready_pct;
    end

    // Input side of the model
    always @(posedge clk_i) begin
        if (!rst_i && tvalid_i && tready_o) begin
            exp_q.push_back(model_beat(tdata_i, cfg_i));
        end
        if (!rst_i && tvalid_i && !tready_o) begin
            saw_stall = 1'b1;
        end
    end

    always @(posedge clk_i) begin : out_monitor
        exp_beat_t got;
        exp_beat_t exp;
        got.data = tdata_o;
        got.err  = err_o;
        got.sat  = sat_o;
        if (!rst_i) begin
            if (prev_stall) begin
                check_equal(tvalid_o, 1, "tvalid_o dropped before transfer");
                check_equal(got, prev_word, "output beat changed while stalled");
            end
            if (tvalid_o && tready_i) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("Output beat appeared with no input beat behind it");
                end else begin
                    exp = exp_q.pop_front();
                    check_equal(got.data, exp.data, "tdata_o");
                    check_equal(got.err, exp.err, "err_o");
                    check_equal(got.sat, exp.sat, "sat_o");
                end
            end
            prev_stall = tvalid_o && !tready_i;
            prev_word  = got;
        end
    end

    initial begin
        logic [CH_NUM-1:0][BITS_IN-1:0] din;
        int                             lat;
        void'($urandom(32'h5672));
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        cfg_i.mode  = dsp_pkg::ROUND_TRUNC;
        cfg_i.shift = '0;
        tdata_i    = '0;
        tvalid_i   = 1'b0;
        tready_i   = 1'b0;

        for (int c = 0; c < 8; c++) begin
            @(posedge clk_i);
            #2;
            check_equal(tvalid_o, 0, "tvalid_o during reset");
            check_equal(tready_o, 0, "tready_o during reset");
        end
        rst_i = 1'b0;
        lat   = 0;
        while (!tready_o && lat < 5) begin
            @(posedge clk_i);
            #2;
            lat++;
        end
        check_equal(tready_o, 1, "tready_o after reset");
        check_equal(lat, 1, "cycles from reset release to tready_o");
        check_equal(tvalid_o, 0, "tvalid_o after reset");

        // Every mode at unity gain
        ready_pct = 70;
        for (int m = 0; m < 3; m++) begin
            cfg_i.mode  = dsp_pkg::round_mode_e'(m);
            cfg_i.shift = '0;
            send_random(BEATS_PER_MODE, 2);
            wait_drain();
        end

        // Rounding edges, positive max must not wrap
        ready_pct   = 100;
        cfg_i.mode  = dsp_pkg::ROUND_NEAREST;
        cfg_i.shift = '0;
        for (int i = 0; i < N_DIRECTED; i++) begin
            for (int ch = 0; ch < CH_NUM; ch++) begin
                din[ch] = edge_vals[(i + ch * 3) % N_DIRECTED];
            end
            send_beat(din, 0);
        end
        wait_drain();

        // Random gain and mode per group
        ready_pct = 70;
        for (int g = 0; g < SHIFT_GROUPS; g++) begin
            cfg_i.mode  = dsp_pkg::round_mode_e'($urandom % 3);
            cfg_i.shift = dsp_pkg::SHIFT_W'($urandom);
            send_random(GROUP_BEATS, 1);
            wait_drain();
        end

        // Heavy back-pressure fills the FIFO
        ready_pct   = 30;
        cfg_i.mode  = dsp_pkg::ROUND_TO_ZERO;
        cfg_i.shift = 4'd2;
        saw_stall   = 1'b0;
        send_random(STALL_BEATS, 0);
        wait_drain();
        check_equal(saw_stall, 1, "tready_o low under back-pressure");

        // Single beat latency through an empty FIFO
        ready_pct = 100;
        repeat (2) begin
            @(posedge clk_i);
            #2;
        end
        send_beat(random_data(), 0);
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (!tvalid_o && lat < 10);
        #2;
        check_equal(lat, 3, "cycles from acceptance to tvalid_o");
        wait_drain();

        if (exp_q.size() != 0) begin
            stop_with_failure("Model queue still holds beats at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: flist.f
logic/dsp_pkg.sv
logic/cfg_pkg.sv
logic/scale_shift.sv
logic/round.sv
logic/credit_fifo.sv
logic/sample_shrink_top.sv
verif/sample_shrink_tb.sv

// File: Bender.yml
package:
  name: sample_shrink

sources:
  # Packages first, dsp_pkg is used by cfg_pkg
  - logic/dsp_pkg.sv
  - logic/cfg_pkg.sv
  # Datapath stages and top level
  - logic/scale_shift.sv
  - logic/round.sv
  - logic/credit_fifo.sv
  - logic/sample_shrink_top.sv
  # Testbench
  - target: test
    files:
      - verif/sample_shrink_tb.sv
